/* Bender.yml */
package:
  name: spectrum_bus

export_include_dirs:
  - logic

sources:
  - logic/zx_bus_pkg.sv
  - logic/zx_mem_pkg.sv
  - logic/zx_cpu_bus_if.sv
  - logic/zx_bus_decode.sv
  - logic/zx_paging.sv
  - logic/zx_memory.sv
  - logic/zx_io_read.sv
  - logic/spectrum_bus.sv
  - target: simulation
    files:
      - sim/spectrum_bus_props.sv
      - sim/spectrum_bus_tb.sv

/* logic/spectrum_bus.sv */
/*
 * Memory and port unit of a 128K Spectrum host board.
 * An external Z80 bus master connects through the plain ports; the ROM is
 * filled through the load port before the CPU starts.
 */

`timescale 1ns/1ns

`include "zx_defines.svh"

module spectrum_bus (
	input  logic clk_sys,
	input  logic reset,
	input  logic [`ZX_ADDR_W-1:0] addr,
	input  logic [`ZX_DATA_W-1:0] cpu_dout,
	output logic [`ZX_DATA_W-1:0] cpu_din,
	input  logic mreq_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,
	input  logic model_48k,
	input  logic [4:0] key_data,
	input  logic tape_in,
	input  logic rom_load_wr,
	input  logic [`ZX_ROM_ADDR_W-1:0] rom_load_addr,
	input  logic [`ZX_DATA_W-1:0] rom_load_data,
	output logic [2:0] border_color,
	output logic ear_out,
	output logic mic_out
);

	zx_mem_pkg::zx_ram_addr_t ram_addr;
	zx_mem_pkg::zx_rom_page_e rom_page;
	logic rom_region;
	logic [`ZX_DATA_W-1:0] ram_rdata;
	logic [`ZX_DATA_W-1:0] rom_rdata;

	zx_cpu_bus_if bus ();

	zx_bus_decode decode_i (
		.clk_sys(clk_sys), .reset(reset), .addr(addr), .cpu_dout(cpu_dout),
		.mreq_n(mreq_n), .iorq_n(iorq_n), .rd_n(rd_n), .wr_n(wr_n), .m1_n(m1_n),
		.bus(bus.decode)
	);

	zx_paging paging_i (
		.clk_sys(clk_sys), .reset(reset), .model_48k(model_48k), .bus(bus.paging),
		.ram_addr(ram_addr), .rom_page(rom_page), .rom_region(rom_region)
	);

	zx_memory memory_i (
		.clk_sys(clk_sys), .bus(bus.memory), .ram_addr(ram_addr), .rom_page(rom_page),
		.rom_region(rom_region), .rom_load_wr(rom_load_wr),
		.rom_load_addr(rom_load_addr), .rom_load_data(rom_load_data),
		.ram_rdata(ram_rdata), .rom_rdata(rom_rdata)
	);

	zx_io_read io_read_i (
		.clk_sys(clk_sys), .reset(reset), .bus(bus.io), .rom_region(rom_region),
		.ram_rdata(ram_rdata), .rom_rdata(rom_rdata), .key_data(key_data),
		.tape_in(tape_in), .cpu_din(cpu_din), .border_color(border_color),
		.ear_out(ear_out), .mic_out(mic_out)
	);

endmodule

/* logic/zx_bus_decode.sv */
/*
 * Z80 bus input stage.
 * Samples the bus levels every clock, classifies the cycle, decodes the
 * I/O port and turns write and fetch levels into one-clock strobes.
 */

`timescale 1ns/1ns

module zx_bus_decode (
	input  logic clk_sys,
	input  logic reset,
	input  logic [15:0] addr,
	input  logic [7:0] cpu_dout,
	input  logic mreq_n,
	input  logic iorq_n,
	input  logic rd_n,
	input  logic wr_n,
	input  logic m1_n,
	zx_cpu_bus_if.decode bus
);

	zx_bus_pkg::zx_cycle_e cycle_next;
	zx_bus_pkg::zx_cycle_e prev_cycle;
	zx_bus_pkg::zx_port_e port_next;

	// Interrupt acknowledge wins, it has iorq_n and m1_n low together
	always_comb begin
		cycle_next = zx_bus_pkg::idle;
		if (!m1_n && !iorq_n)
			cycle_next = zx_bus_pkg::int_ack;
		else if (!m1_n && !mreq_n && !rd_n)
			cycle_next = zx_bus_pkg::opcode_fetch;
		else if (!mreq_n && !rd_n)
			cycle_next = zx_bus_pkg::mem_read;
		else if (!mreq_n && !wr_n)
			cycle_next = zx_bus_pkg::mem_write;
		else if (!iorq_n && !rd_n)
			cycle_next = zx_bus_pkg::io_read;
		else if (!iorq_n && !wr_n)
			cycle_next = zx_bus_pkg::io_write;
	end

	// ULA answers on any even address, 7FFD on A15 and A1 low
	always_comb begin
		if (!addr[0])
			port_next = zx_bus_pkg::port_ula;
		else if (!addr[15] && !addr[1])
			port_next = zx_bus_pkg::port_page;
		else
			port_next = zx_bus_pkg::port_none;
	end

	always_ff @(posedge clk_sys) begin
		bus.addr <= addr;
		bus.wdata <= cpu_dout;
		if (reset) begin
			bus.cycle <= zx_bus_pkg::idle;
			bus.port <= zx_bus_pkg::port_none;
			prev_cycle <= zx_bus_pkg::idle;
			bus.mem_wr_stb <= 1'b0;
			bus.io_wr_stb <= 1'b0;
			bus.fetch_stb <= 1'b0;
		end else begin
			bus.cycle <= cycle_next;
			bus.port <= port_next;
			prev_cycle <= bus.cycle;
			// Rising edge of each level against the sample before it
			bus.mem_wr_stb <= (bus.cycle == zx_bus_pkg::mem_write) &&
				(prev_cycle != zx_bus_pkg::mem_write);
			bus.io_wr_stb <= (bus.cycle == zx_bus_pkg::io_write) &&
				(prev_cycle != zx_bus_pkg::io_write);
			bus.fetch_stb <= (bus.cycle == zx_bus_pkg::opcode_fetch) &&
				(prev_cycle != zx_bus_pkg::opcode_fetch);
		end
	end

endmodule

/* logic/zx_bus_pkg.sv */
/*
 * Types that describe the Z80 side of the unit.
 * Bus cycle kinds and the I/O port that a cycle addresses.
 */

package zx_bus_pkg;

	// Kind of bus cycle seen on the registered Z80 levels
	typedef enum logic [2:0] {
		idle         = 3'd0,
		mem_read     = 3'd1,
		mem_write    = 3'd2,
		io_read      = 3'd3,
		io_write     = 3'd4,
		opcode_fetch = 3'd5,
		int_ack      = 3'd6
	} zx_cycle_e;

	// I/O port selected by the address of an I/O cycle
	typedef enum logic [1:0] {
		port_ula  = 2'd0,
		port_page = 2'd1,
		port_none = 2'd2
	} zx_port_e;

endpackage

/* logic/zx_cpu_bus_if.sv */
/*
 * Decoded Z80 bus cycles, shared between the decoder and the blocks behind it.
 * The decoder owns every signal; the other blocks only listen.
 */

`timescale 1ns/1ns

`include "zx_defines.svh"

interface zx_cpu_bus_if;

	// Registered copies of the bus
	logic [`ZX_ADDR_W-1:0] addr;
	logic [`ZX_DATA_W-1:0] wdata;

	zx_bus_pkg::zx_cycle_e cycle;
	zx_bus_pkg::zx_port_e port;

	// One-clock pulses at the start of a cycle
	logic mem_wr_stb;
	logic io_wr_stb;
	logic fetch_stb;

	modport decode (output addr, wdata, cycle, port, mem_wr_stb, io_wr_stb, fetch_stb);
	modport paging (input addr, wdata, cycle, port, mem_wr_stb, io_wr_stb, fetch_stb);
	modport memory (input addr, wdata, cycle, port, mem_wr_stb, io_wr_stb, fetch_stb);
	modport io (input addr, wdata, cycle, port, mem_wr_stb, io_wr_stb, fetch_stb);

endinterface

/* logic/zx_defines.svh */
/*
 * Fixed sizes and constants of the 128K Spectrum memory and port unit.
 * Include this header wherever a bus width, bank number or port bit is needed.
 */

`ifndef ZX_DEFINES_SVH
`define ZX_DEFINES_SVH

// Z80 bus widths
`define ZX_ADDR_W 16
`define ZX_DATA_W 8

// Memory geometry, eight 16 KB RAM banks and two 16 KB ROM pages
`define ZX_BANK_W 3
`define ZX_RAM_ADDR_W 17
`define ZX_ROM_ADDR_W 15

// Port 7FFD bit positions
`define ZX_PAGE_LOCK_BIT 5
`define ZX_PAGE_ROM_BIT 4

// Banks that never move
`define ZX_BANK_SCREEN 3'd5
`define ZX_BANK_MID 3'd2

`define ZX_IDLE_BUS 8'hFF

`endif

/* logic/zx_io_read.sv */
/*
 * Output side of the unit.
 * Holds the ULA port register for border, EAR and MIC, and selects the byte
 * returned to the CPU for every kind of read cycle.
 */

`timescale 1ns/1ns

`include "zx_defines.svh"

module zx_io_read (
	input  logic clk_sys,
	input  logic reset,
	zx_cpu_bus_if.io bus,
	input  logic rom_region,
	input  logic [`ZX_DATA_W-1:0] ram_rdata,
	input  logic [`ZX_DATA_W-1:0] rom_rdata,
	input  logic [4:0] key_data,
	input  logic tape_in,
	output logic [`ZX_DATA_W-1:0] cpu_din,
	output logic [2:0] border_color,
	output logic ear_out,
	output logic mic_out
);

	logic ula_write;
	logic [`ZX_DATA_W-1:0] mem_rdata;
	logic [`ZX_DATA_W-1:0] ula_rdata;

	// ============================================================
	// ULA port write
	// ============================================================

	assign ula_write = bus.io_wr_stb && (bus.port == zx_bus_pkg::port_ula);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			border_color <= 3'd0;
			ear_out <= 1'b0;
			mic_out <= 1'b0;
		end else if (ula_write) begin
			border_color <= bus.wdata[2:0];
			ear_out <= bus.wdata[4];
			mic_out <= bus.wdata[3];
		end
	end

	// ============================================================
	// CPU read data
	// ============================================================

	assign mem_rdata = rom_region ? rom_rdata : ram_rdata;

	// Bits 7 and 5 float high on a real ULA
	assign ula_rdata = {1'b1, ~tape_in, 1'b1, key_data};

	always_comb begin
		case (bus.cycle)
			zx_bus_pkg::mem_read,
			zx_bus_pkg::opcode_fetch: cpu_din = mem_rdata;
			zx_bus_pkg::io_read: begin
				if (bus.port == zx_bus_pkg::port_ula)
					cpu_din = ula_rdata;
				else
					cpu_din = `ZX_IDLE_BUS;
			end
			// Interrupt acknowledge also lands here and reads FF
			default: cpu_din = `ZX_IDLE_BUS;
		endcase
	end

endmodule

/* logic/zx_mem_pkg.sv */
/*
 * Types that describe the memory side of the unit.
 * ROM page selection and the RAM and ROM array addresses.
 */

`include "zx_defines.svh"

package zx_mem_pkg;

	// ROM page in the 0000-3FFF window
	typedef enum logic [0:0] {
		rom_128_editor = 1'b0,
		rom_48_basic   = 1'b1
	} zx_rom_page_e;

	// Bank number in the top bits, offset inside the bank below
	typedef logic [`ZX_RAM_ADDR_W-1:0] zx_ram_addr_t;

	// ROM page in the top bit, offset inside the page below
	typedef logic [`ZX_ROM_ADDR_W-1:0] zx_rom_addr_t;

endpackage

/* logic/zx_memory.sv */
/*
 * RAM and ROM arrays of the machine.
 * 128 KB RAM written by CPU memory writes outside the ROM region, 32 KB ROM
 * filled only through the load port. Both read ports register the address.
 */

`timescale 1ns/1ns

`include "zx_defines.svh"

module zx_memory (
	input  logic clk_sys,
	zx_cpu_bus_if.memory bus,
	input  zx_mem_pkg::zx_ram_addr_t ram_addr,
	input  zx_mem_pkg::zx_rom_page_e rom_page,
	input  logic rom_region,
	input  logic rom_load_wr,
	input  zx_mem_pkg::zx_rom_addr_t rom_load_addr,
	input  logic [`ZX_DATA_W-1:0] rom_load_data,
	output logic [`ZX_DATA_W-1:0] ram_rdata,
	output logic [`ZX_DATA_W-1:0] rom_rdata
);

	logic [`ZX_DATA_W-1:0] ram [0:(1 << `ZX_RAM_ADDR_W)-1];
	logic [`ZX_DATA_W-1:0] rom [0:(1 << `ZX_ROM_ADDR_W)-1];

	zx_mem_pkg::zx_ram_addr_t ram_addr_q;
	zx_mem_pkg::zx_rom_addr_t rom_addr_q;

	// ============================================================
	// RAM
	// ============================================================

	// Writes into 0000-3FFF are dropped, the ROM sits there
	always_ff @(posedge clk_sys) begin
		if (bus.mem_wr_stb && !rom_region)
			ram[ram_addr] <= bus.wdata;
		ram_addr_q <= ram_addr;
	end

	assign ram_rdata = ram[ram_addr_q];

	// ============================================================
	// ROM
	// ============================================================

	always_ff @(posedge clk_sys) begin
		if (rom_load_wr)
			rom[rom_load_addr] <= rom_load_data;
		rom_addr_q <= {rom_page, bus.addr[13:0]};
	end

	assign rom_rdata = rom[rom_addr_q];

endmodule

/* logic/zx_paging.sv */
/*
 * 128K paging through port 7FFD.
 * Holds the page register and the 48K model flag, and maps the CPU address
 * onto a RAM bank or the ROM region with its page.
 */

`timescale 1ns/1ns

`include "zx_defines.svh"

module zx_paging (
	input  logic clk_sys,
	input  logic reset,
	input  logic model_48k,
	zx_cpu_bus_if.paging bus,
	output zx_mem_pkg::zx_ram_addr_t ram_addr,
	output zx_mem_pkg::zx_rom_page_e rom_page,
	output logic rom_region
);

	logic [`ZX_DATA_W-1:0] page_reg;
	logic zx48;
	logic page_disable;
	logic page_write;
	logic [`ZX_BANK_W-1:0] bank;

	// ============================================================
	// Page register
	// ============================================================

	// Lock bit set or 48K model freezes the register until reset
	assign page_disable = zx48 | page_reg[`ZX_PAGE_LOCK_BIT];
	assign page_write = bus.io_wr_stb && (bus.port == zx_bus_pkg::port_page) &&
		!page_disable;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_reg <= '0;
			zx48 <= model_48k;
		end else if (page_write) begin
			page_reg <= bus.wdata;
		end
	end

	// ============================================================
	// Address map
	// ============================================================

	always_comb begin
		rom_region = 1'b0;
		case (bus.addr[15:14])
			2'd0: begin
				bank = '0;
				rom_region = 1'b1;
			end
			2'd1: bank = `ZX_BANK_SCREEN;
			2'd2: bank = `ZX_BANK_MID;
			default: bank = page_reg[`ZX_BANK_W-1:0];
		endcase
	end

	assign ram_addr = {bank, bus.addr[13:0]};

	// 48K model always sees the 48K BASIC ROM
	assign rom_page = (page_reg[`ZX_PAGE_ROM_BIT] || zx48) ?
		zx_mem_pkg::rom_48_basic : zx_mem_pkg::rom_128_editor;

endmodule

/* sim/spectrum_bus_props.sv */
/*
 * Concurrent checks on the decoder strobes and the 7FFD page register.
 * Bound into the paging block, which receives every decoder strobe.
 */

`timescale 1ns/1ns

`include "zx_defines.svh"

module spectrum_bus_props (
	input logic clk_sys,
	input logic reset,
	input logic mem_wr_stb,
	input logic io_wr_stb,
	input logic fetch_stb,
	input logic [7:0] page_reg
);

	// Strobes are single-clock pulses
	mem_stb_single: assert property (@(posedge clk_sys) disable iff (reset)
		mem_wr_stb |=> !mem_wr_stb)
		else $error("mem_wr_stb stayed high for more than one clock");
	io_stb_single: assert property (@(posedge clk_sys) disable iff (reset)
		io_wr_stb |=> !io_wr_stb)
		else $error("io_wr_stb stayed high for more than one clock");
	fetch_stb_single: assert property (@(posedge clk_sys) disable iff (reset)
		fetch_stb |=> !fetch_stb)
		else $error("fetch_stb stayed high for more than one clock");

	stb_exclusive: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_wr_stb && io_wr_stb))
		else $error("memory and I/O write strobes are high together");

	// Only reset may release the lock
	page_frozen: assert property (@(posedge clk_sys) disable iff (reset)
		page_reg[`ZX_PAGE_LOCK_BIT] |=> $stable(page_reg))
		else $error("page register changed while the lock bit was set");

endmodule

bind zx_paging spectrum_bus_props props_i (
	.clk_sys(clk_sys), .reset(reset), .mem_wr_stb(bus.mem_wr_stb),
	.io_wr_stb(bus.io_wr_stb), .fetch_stb(bus.fetch_stb), .page_reg(page_reg)
);

/* sim/spectrum_bus_tb.sv */
/*
 * Directed testbench for the Spectrum memory and port unit.
 * Plays Z80 bus cycles of four clocks each and checks ROM paging, RAM
 * banking, the paging lock, the 48K model and the ULA port.
 */

`timescale 1ns/1ns

module spectrum_bus_tb;

	localparam int CLK_PERIOD = 40;
	localparam int RESET_CYCLES = 16;
	localparam int HOLD_CLOCKS = 4;
	localparam int ROM_SAMPLES = 16;
	localparam int ULA_TIMEOUT = 8;
	localparam int WATCHDOG_CLOCKS = 50000;

	logic clk_sys;
	logic reset;
	logic [15:0] addr;
	logic [7:0] cpu_dout;
	logic [7:0] cpu_din;
	logic mreq_n, iorq_n, rd_n, wr_n, m1_n;
	logic model_48k;
	logic [4:0] key_data;
	logic tape_in;
	logic rom_load_wr;
	logic [14:0] rom_load_addr;
	logic [7:0] rom_load_data;
	logic [2:0] border_color;
	logic ear_out;
	logic mic_out;

	// Expected contents built from what the testbench wrote
	logic [7:0] rom_model [0:32767];
	logic [13:0] rom_offs [0:ROM_SAMPLES-1];
	logic [7:0] bank_data [0:7];
	int checks, errors, test_errors, tests_run;

	spectrum_bus spectrum_bus_i (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(CLK_PERIOD / 2) clk_sys = ~clk_sys;
	end

	// ============================================================
	// Bus and bookkeeping tasks
	// ============================================================

	task automatic wait_clocks(input int n);
		for (int i = 0; i < n; i++)
			@(negedge clk_sys);
	endtask

	// Levels are {mreq_n, iorq_n, rd_n, wr_n, m1_n}
	// One idle clock follows each cycle
	task automatic run_cycle(input logic [15:0] a, input logic [7:0] d,
			input logic [4:0] levels, output logic [7:0] din);
		addr = a;
		cpu_dout = d;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n} = levels;
		wait_clocks(HOLD_CLOCKS);
		din = cpu_din;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
		wait_clocks(1);
	endtask

	task automatic mem_write(input logic [15:0] a, input logic [7:0] d);
		logic [7:0] ignored;
		run_cycle(a, d, 5'b01101, ignored);
	endtask

	task automatic mem_read(input logic [15:0] a, output logic [7:0] d);
		run_cycle(a, 8'h00, 5'b01011, d);
	endtask

	task automatic io_write(input logic [15:0] a, input logic [7:0] d);
		logic [7:0] ignored;
		run_cycle(a, d, 5'b10101, ignored);
	endtask

	task automatic io_read(input logic [15:0] a, output logic [7:0] d);
		run_cycle(a, 8'h00, 5'b10011, d);
	endtask

	task automatic rom_load(input logic [14:0] a, input logic [7:0] d);
		rom_load_addr = a;
		rom_load_data = d;
		rom_load_wr = 1'b1;
		wait_clocks(HOLD_CLOCKS);
		rom_load_wr = 1'b0;
		rom_model[a] = d;
	endtask

	task automatic apply_reset(input logic model);
		model_48k = model;
		reset = 1'b1;
		wait_clocks(RESET_CYCLES);
		reset = 1'b0;
		wait_clocks(1);
	endtask

	task automatic compare_byte(input string name, input logic [7:0] exp,
			input logic [7:0] got);
		checks++;
		assert (got === exp) else begin
			$display("FAIL %s expected %02h actual %02h", name, exp, got);
			test_errors++;
		end
	endtask

	task automatic finish_test(input string name);
		tests_run++;
		errors += test_errors;
		if (test_errors == 0)
			$display("%s: passed", name);
		else
			$display("%s: %0d errors", name, test_errors);
		test_errors = 0;
	endtask

	// ============================================================
	// Directed tests
	// ============================================================

	task automatic rom_paging();
		logic [7:0] got;
		for (int i = 0; i < ROM_SAMPLES; i++) begin
			rom_offs[i] = 14'($urandom);
			rom_load({1'b0, rom_offs[i]}, 8'($urandom));
			rom_load({1'b1, rom_offs[i]}, 8'($urandom));
		end
		for (int i = 0; i < ROM_SAMPLES; i++) begin
			mem_read({2'b00, rom_offs[i]}, got);
			compare_byte("rom_pages page 0", rom_model[{1'b0, rom_offs[i]}], got);
		end
		io_write(16'h7FFD, 8'h10);
		for (int i = 0; i < ROM_SAMPLES; i++) begin
			mem_read({2'b00, rom_offs[i]}, got);
			compare_byte("rom_pages page 1", rom_model[{1'b1, rom_offs[i]}], got);
		end
		mem_write({2'b00, rom_offs[0]}, ~rom_model[{1'b1, rom_offs[0]}]);
		mem_read({2'b00, rom_offs[0]}, got);
		compare_byte("rom_pages write ignored", rom_model[{1'b1, rom_offs[0]}], got);
		finish_test("rom_pages");
	endtask

	task automatic ram_banking();
		logic [7:0] got;
		// Bank number in the low bits keeps the bytes distinct
		for (int b = 0; b < 8; b++) begin
			bank_data[b] = {5'($urandom), 3'(b)};
			io_write(16'h7FFD, 8'(b));
			mem_write(16'hC000, bank_data[b]);
		end
		for (int b = 0; b < 8; b++) begin
			io_write(16'h7FFD, 8'(b));
			mem_read(16'hC000, got);
			compare_byte($sformatf("ram_banks bank %0d", b), bank_data[b], got);
		end
		mem_read(16'h4000, got);
		compare_byte("ram_banks 4000", bank_data[5], got);
		mem_read(16'h8000, got);
		compare_byte("ram_banks 8000", bank_data[2], got);
		// Opcode fetch with m1_n low reads memory like a plain read
		run_cycle(16'h8000, 8'h00, 5'b01010, got);
		compare_byte("ram_banks fetch 8000", bank_data[2], got);
		finish_test("ram_banks");
	endtask

	task automatic paging_lock();
		logic [7:0] got;
		io_write(16'h7FFD, 8'h23);
		io_write(16'h7FFD, 8'h16);
		mem_read(16'hC000, got);
		compare_byte("paging_lock bank", bank_data[3], got);
		mem_read({2'b00, rom_offs[1]}, got);
		compare_byte("paging_lock rom", rom_model[{1'b0, rom_offs[1]}], got);
		apply_reset(1'b0);
		io_write(16'h7FFD, 8'h16);
		mem_read(16'hC000, got);
		compare_byte("paging_lock bank after reset", bank_data[6], got);
		mem_read({2'b00, rom_offs[1]}, got);
		compare_byte("paging_lock rom after reset", rom_model[{1'b1, rom_offs[1]}], got);
		finish_test("paging_lock");
	endtask

	task automatic mode_48k();
		logic [7:0] got;
		apply_reset(1'b1);
		io_write(16'h7FFD, 8'h03);
		mem_read(16'hC000, got);
		compare_byte("model_48k bank", bank_data[0], got);
		mem_read({2'b00, rom_offs[2]}, got);
		compare_byte("model_48k rom", rom_model[{1'b1, rom_offs[2]}], got);
		apply_reset(1'b0);
		finish_test("model_48k");
	endtask

	task automatic ula_port();
		logic [7:0] got;
		logic [7:0] wval;
		logic [7:0] exp_read;
		int waited;
		wval = 8'($urandom);
		// EAR and MIC get opposite values so a swapped pair shows up
		wval[4] = ~wval[3];
		// Second pass writes the complement so every output bit toggles
		for (int pass = 0; pass < 2; pass++) begin
			io_write(16'h00FE, wval);
			waited = 0;
			while ((border_color !== wval[2:0] || ear_out !== wval[4] ||
					mic_out !== wval[3]) && waited < ULA_TIMEOUT) begin
				@(negedge clk_sys);
				waited++;
			end
			assert (waited < ULA_TIMEOUT) else begin
				$display("ula_port: border, EAR and MIC did not follow the FE write");
				test_errors++;
			end
			compare_byte("ula_port border", {5'b0, wval[2:0]}, {5'b0, border_color});
			compare_byte("ula_port ear", {7'b0, wval[4]}, {7'b0, ear_out});
			compare_byte("ula_port mic", {7'b0, wval[3]}, {7'b0, mic_out});
			wval = ~wval;
		end
		key_data = 5'($urandom);
		tape_in = 1'($urandom);
		// Bits 7 and 5 high, bit 6 set while the tape input is low
		exp_read = {3'b101, key_data} | (tape_in ? 8'h00 : 8'h40);
		io_read(16'h00FE, got);
		compare_byte("ula_port read", exp_read, got);
		io_read(16'h00FF, got);
		compare_byte("ula_port odd port", 8'hFF, got);
		run_cycle(16'h0038, 8'h00, 5'b10110, got);
		compare_byte("ula_port int ack", 8'hFF, got);
		finish_test("ula_port");
	endtask

	// ============================================================
	// Run
	// ============================================================

	initial begin
		void'($urandom(32'h6466));
		reset = 1'b1;
		addr = 16'h0000;
		cpu_dout = 8'h00;
		{mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
		model_48k = 1'b0;
		key_data = 5'h1F;
		tape_in = 1'b0;
		rom_load_wr = 1'b0;
		rom_load_addr = '0;
		rom_load_data = 8'h00;
		checks = 0;
		errors = 0;
		test_errors = 0;
		tests_run = 0;
		apply_reset(1'b0);
		rom_paging();
		ram_banking();
		paging_lock();
		mode_48k();
		ula_port();
		$display("Tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
		if (errors == 0)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog for a bus sequence that never ends
	initial begin
		for (int t = 0; t < WATCHDOG_CLOCKS; t++)
			@(posedge clk_sys);
		$display("Timeout, the run did not finish within %0d clocks", WATCHDOG_CLOCKS);
		$display("Something failed");
		$finish;
	end

endmodule

/* spectrum_bus.f */
+incdir+logic
logic/zx_bus_pkg.sv
logic/zx_mem_pkg.sv
logic/zx_cpu_bus_if.sv
logic/zx_bus_decode.sv
logic/zx_paging.sv
logic/zx_memory.sv
logic/zx_io_read.sv
logic/spectrum_bus.sv
sim/spectrum_bus_props.sv
sim/spectrum_bus_tb.sv
